//--- common/issue_pkg.sv
`default_nettype none

package issue_pkg;

    localparam int NUM_THREADS = 4;
    localparam int WARP_BITS = 2;
    localparam int UUID_BITS = 8;
    localparam int REG_BITS = 5;
    localparam int XLEN = 32;
    localparam int INSTR_BITS = 32;
    localparam int OP_BITS = 4;
    localparam int IMM_BITS = 11;

    // microcode table geometry
    localparam int UOP_TABLE_SIZE = 64;
    localparam int UPC_BITS = $clog2(UOP_TABLE_SIZE);
    localparam int UOPS_PER_SET = 8;

    // the buffer depth must stay a power of two so the pointers wrap on their own
    localparam int IBUF_DEPTH = 4;
    localparam int IBUF_PTR_BITS = $clog2(IBUF_DEPTH);
    localparam int IBUF_CNT_BITS = IBUF_PTR_BITS + 1;

    // op code that every tensor micro-op hands to the FPU
    localparam logic [OP_BITS-1:0] OP_FMADD = 4'd12;

    typedef enum logic [1:0] {
        EX_ALU    = 2'd0,
        EX_LSU    = 2'd1,
        EX_FPU    = 2'd2,
        EX_TENSOR = 2'd3
    } ex_type_e;

    typedef enum logic {
        UBR_NEXT   = 1'b0,
        UBR_FINISH = 1'b1
    } ubr_e;

    // instruction word is ex[31:30] op[29:26] rd[25:21] rs1[20:16] rs2[15:11] imm[10:0]
    typedef struct packed {
        logic [INSTR_BITS-1:0]  instr;
        logic [WARP_BITS-1:0]   wis;
        logic [NUM_THREADS-1:0] tmask;
    } fetch_t;

    typedef struct packed {
        logic [UUID_BITS-1:0]   uuid;
        logic [WARP_BITS-1:0]   wis;
        logic [NUM_THREADS-1:0] tmask;
        ex_type_e               ex_type;
        logic [OP_BITS-1:0]     op_type;
        logic                   wb;
        logic                   use_imm;
        logic [XLEN-1:0]        imm;
        logic [REG_BITS-1:0]    rd;
        logic [REG_BITS-1:0]    rs1;
        logic [REG_BITS-1:0]    rs2;
        logic [REG_BITS-1:0]    rs3;
    } decoded_t;

    // one row of the microcode table, sequencing fields ahead of the operation
    typedef struct packed {
        ubr_e                ubr;
        logic [UPC_BITS-1:0] next_upc;
        ex_type_e            ex_type;
        logic [OP_BITS-1:0]  op_type;
        logic                wb;
        logic                use_imm;
        logic [XLEN-1:0]     imm;
        logic [REG_BITS-1:0] rd;
        logic [REG_BITS-1:0] rs1;
        logic [REG_BITS-1:0] rs2;
        logic [REG_BITS-1:0] rs3;
    } uop_entry_t;

endpackage

`default_nettype wire

//--- issue_front.f
+incdir+uop_sequencer
common/issue_pkg.sv
source/inst_decoder.sv
uop_sequencer/uop_sequencer.sv
source/inst_buffer.sv
source/issue_front.sv
verification/issue_front_sva.sv
verification/issue_front_tb.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns -f issue_front.f \
    --top-module issue_front_tb -Mdir obj_dir -o issue_front_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/issue_front_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^NO ERRORS$"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

//--- source/inst_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module inst_buffer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     in_valid,
    input  wire issue_pkg::decoded_t in_data,
    output logic                    in_ready,
    output logic                    out_valid,
    output issue_pkg::decoded_t     out_data,
    input  wire                     out_ready
);
    import issue_pkg::*;

    decoded_t                 mem [IBUF_DEPTH];
    logic [IBUF_PTR_BITS-1:0] wr_ptr;
    logic [IBUF_PTR_BITS-1:0] rd_ptr;
    logic [IBUF_CNT_BITS-1:0] count;
    logic                     full;
    logic                     wr_en;
    logic                     rd_en;

    assign full = (count == IBUF_CNT_BITS'(IBUF_DEPTH));
    assign out_valid = (count != '0);

    // a full buffer still takes a write when the head leaves in the same cycle
    assign in_ready = ~full | out_ready;

    assign wr_en = in_valid & in_ready;
    assign rd_en = out_valid & out_ready;

    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            // pointers wrap by overflow since the depth is a power of two
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   fetch_valid,
    input  wire issue_pkg::fetch_t fetch_data,
    output logic                  fetch_ready,
    output logic                  dec_valid,
    output issue_pkg::decoded_t   dec_data,
    input  wire                   dec_ready
);
    import issue_pkg::*;

    ex_type_e             ex;
    logic [REG_BITS-1:0]  rd;
    logic [UUID_BITS-1:0] uuid_cnt;
    logic                 fetch_fire;
    decoded_t             dec_next;

    // the stage takes a new word when empty or when its current word leaves this cycle
    assign fetch_ready = ~dec_valid | dec_ready;
    assign fetch_fire = fetch_valid & fetch_ready;

    assign ex = ex_type_e'(fetch_data.instr[31:30]);
    assign rd = fetch_data.instr[25:21];

    always_comb begin
        dec_next.uuid = uuid_cnt;
        dec_next.wis = fetch_data.wis;
        dec_next.tmask = fetch_data.tmask;
        dec_next.ex_type = ex;
        dec_next.op_type = fetch_data.instr[29:26];
        dec_next.rd = rd;
        dec_next.rs1 = fetch_data.instr[20:16];
        dec_next.rs2 = fetch_data.instr[15:11];
        // tensor ops accumulate in place, so the destination is also read
        dec_next.rs3 = (ex == EX_TENSOR) ? rd : '0;
        dec_next.wb = (rd != '0);
        dec_next.use_imm = (ex == EX_LSU);
        dec_next.imm = {{(XLEN-IMM_BITS){fetch_data.instr[IMM_BITS-1]}},
                        fetch_data.instr[IMM_BITS-1:0]};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            uuid_cnt <= '0;
        end else begin
            if (fetch_ready) begin
                dec_valid <= fetch_valid;
            end
            // counter wraps naturally at 256
            if (fetch_fire) begin
                uuid_cnt <= uuid_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            dec_data <= dec_next;
        end
    end

endmodule

`default_nettype wire

//--- source/issue_front.sv
`timescale 1ns/1ns
`default_nettype none

module issue_front (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     fetch_valid,
    input  wire issue_pkg::fetch_t   fetch_data,
    output wire                     fetch_ready,
    output wire                     issue_valid,
    output wire issue_pkg::decoded_t issue_data,
    input  wire                     issue_ready
);
    import issue_pkg::*;

    // decoder to sequencer
    wire           dec_valid;
    wire           dec_ready;
    wire decoded_t dec_data;

    // sequencer to buffer
    wire           seq_valid;
    wire           seq_ready;
    wire decoded_t seq_data;

    inst_decoder u_decoder (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .fetch_ready (fetch_ready),
        .dec_valid   (dec_valid),
        .dec_data    (dec_data),
        .dec_ready   (dec_ready)
    );

    uop_sequencer u_sequencer (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dec_valid),
        .in_data   (dec_data),
        .in_ready  (dec_ready),
        .out_valid (seq_valid),
        .out_data  (seq_data),
        .out_ready (seq_ready)
    );

    inst_buffer u_buffer (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (seq_valid),
        .in_data   (seq_data),
        .in_ready  (seq_ready),
        .out_valid (issue_valid),
        .out_data  (issue_data),
        .out_ready (issue_ready)
    );

endmodule

`default_nettype wire

//--- uop_sequencer/tensor_ucode.svh
`ifndef TENSOR_UCODE_SVH
`define TENSOR_UCODE_SVH

// fields are ubr, next_upc, ex_type, op_type, wb, use_imm, imm, rd, rs1, rs2, rs3
// A lives in f0 to f7, each set reads its own pair of B and C registers

// set 0 reads B from f8 and f9 and accumulates into f16 and f17
6'd0: uop = '{UBR_NEXT, 6'd1, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd16, 5'd0, 5'd8, 5'd16};
6'd1: uop = '{UBR_NEXT, 6'd2, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd17, 5'd1, 5'd9, 5'd17};
6'd2: uop = '{UBR_NEXT, 6'd3, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd16, 5'd2, 5'd8, 5'd16};
6'd3: uop = '{UBR_NEXT, 6'd4, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd17, 5'd3, 5'd9, 5'd17};
6'd4: uop = '{UBR_NEXT, 6'd5, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd16, 5'd4, 5'd8, 5'd16};
6'd5: uop = '{UBR_NEXT, 6'd6, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd17, 5'd5, 5'd9, 5'd17};
6'd6: uop = '{UBR_NEXT, 6'd7, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd16, 5'd6, 5'd8, 5'd16};
6'd7: uop = '{UBR_FINISH, 6'd0, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd17, 5'd7, 5'd9, 5'd17};

// set 1 uses f10 and f11 with f18 and f19
6'd8: uop = '{UBR_NEXT, 6'd9, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd18, 5'd0, 5'd10, 5'd18};
6'd9: uop = '{UBR_NEXT, 6'd10, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd19, 5'd1, 5'd11, 5'd19};
6'd10: uop = '{UBR_NEXT, 6'd11, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd18, 5'd2, 5'd10, 5'd18};
6'd11: uop = '{UBR_NEXT, 6'd12, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd19, 5'd3, 5'd11, 5'd19};
6'd12: uop = '{UBR_NEXT, 6'd13, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd18, 5'd4, 5'd10, 5'd18};
6'd13: uop = '{UBR_NEXT, 6'd14, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd19, 5'd5, 5'd11, 5'd19};
6'd14: uop = '{UBR_NEXT, 6'd15, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd18, 5'd6, 5'd10, 5'd18};
6'd15: uop = '{UBR_FINISH, 6'd0, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd19, 5'd7, 5'd11, 5'd19};

// set 2 uses f12 and f13 with f20 and f21
6'd16: uop = '{UBR_NEXT, 6'd17, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd20, 5'd0, 5'd12, 5'd20};
6'd17: uop = '{UBR_NEXT, 6'd18, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd21, 5'd1, 5'd13, 5'd21};
6'd18: uop = '{UBR_NEXT, 6'd19, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd20, 5'd2, 5'd12, 5'd20};
6'd19: uop = '{UBR_NEXT, 6'd20, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd21, 5'd3, 5'd13, 5'd21};
6'd20: uop = '{UBR_NEXT, 6'd21, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd20, 5'd4, 5'd12, 5'd20};
6'd21: uop = '{UBR_NEXT, 6'd22, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd21, 5'd5, 5'd13, 5'd21};
6'd22: uop = '{UBR_NEXT, 6'd23, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd20, 5'd6, 5'd12, 5'd20};
6'd23: uop = '{UBR_FINISH, 6'd0, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd21, 5'd7, 5'd13, 5'd21};

// set 3 uses f14 and f15 with f22 and f23
6'd24: uop = '{UBR_NEXT, 6'd25, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd22, 5'd0, 5'd14, 5'd22};
6'd25: uop = '{UBR_NEXT, 6'd26, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd23, 5'd1, 5'd15, 5'd23};
6'd26: uop = '{UBR_NEXT, 6'd27, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd22, 5'd2, 5'd14, 5'd22};
6'd27: uop = '{UBR_NEXT, 6'd28, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd23, 5'd3, 5'd15, 5'd23};
6'd28: uop = '{UBR_NEXT, 6'd29, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd22, 5'd4, 5'd14, 5'd22};
6'd29: uop = '{UBR_NEXT, 6'd30, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd23, 5'd5, 5'd15, 5'd23};
6'd30: uop = '{UBR_NEXT, 6'd31, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd22, 5'd6, 5'd14, 5'd22};
6'd31: uop = '{UBR_FINISH, 6'd0, EX_FPU, OP_FMADD, 1'b1, 1'b0, 32'd0, 5'd23, 5'd7, 5'd15, 5'd23};

`endif

//--- uop_sequencer/uop_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module uop_sequencer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     in_valid,
    input  wire issue_pkg::decoded_t in_data,
    output logic                    in_ready,
    output logic                    out_valid,
    output issue_pkg::decoded_t     out_data,
    input  wire                     out_ready
);
    import issue_pkg::*;

    uop_entry_t          uop;
    logic [UPC_BITS-1:0] upc;
    logic [UPC_BITS-1:0] upc_r;
    logic [1:0]          set_sel;
    logic                started_r;
    logic                is_tensor;
    logic                uop_fire;
    logic                uop_last;

    assign is_tensor = in_valid && (in_data.ex_type == EX_TENSOR);
    assign set_sel = in_data.op_type[1:0];

    // the first micro-op comes from the base entry of the set, later ones from upc_r
    assign upc = started_r ? upc_r : UPC_BITS'(set_sel * UOPS_PER_SET);

    always_comb begin
        case (upc)
            `include "tensor_ucode.svh"
            default: uop = '0;
        endcase
    end

    assign uop_fire = is_tensor && out_ready;
    assign uop_last = (uop.ubr == UBR_FINISH);

    always_comb begin
        if (is_tensor) begin
            out_valid = 1'b1;
            // the tensor instruction is consumed together with its last micro-op
            in_ready = uop_fire && uop_last;
            out_data.uuid = in_data.uuid;
            out_data.wis = in_data.wis;
            out_data.tmask = in_data.tmask;
            out_data.ex_type = uop.ex_type;
            out_data.op_type = uop.op_type;
            out_data.wb = uop.wb;
            out_data.use_imm = uop.use_imm;
            out_data.imm = uop.imm;
            out_data.rd = uop.rd;
            out_data.rs1 = uop.rs1;
            out_data.rs2 = uop.rs2;
            out_data.rs3 = uop.rs3;
        end else begin
            // everything else goes straight through in the same cycle
            out_valid = in_valid;
            in_ready = out_ready;
            out_data = in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            started_r <= 1'b0;
            upc_r <= '0;
        end else if (uop_fire) begin
            if (uop_last) begin
                // clearing here lets the next tensor op start on the following cycle
                started_r <= 1'b0;
            end else begin
                started_r <= 1'b1;
                upc_r <= uop.next_upc;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/issue_front_sva.sv
`timescale 1ns/1ns
`default_nettype none

module issue_front_sva (
    input wire                      clk,
    input wire                      reset,
    input wire                      fetch_ready,
    input wire                      issue_valid,
    input wire                      issue_ready,
    input wire issue_pkg::decoded_t issue_data,
    input wire                      dec_valid,
    input wire                      dec_ready,
    input wire issue_pkg::decoded_t dec_data
);

    // the cycle after reset the issue port is empty and fetch is open
    a_idle_after_reset: assert property (@(posedge clk)
        reset |=> (!issue_valid && fetch_ready))
        else $error("issue_valid or fetch_ready not idle after reset");

    a_issue_stable: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue_data)))
        else $error("issue_data changed while stalled");

    // a stalled decoder output must hold until the sequencer takes it
    a_dec_stable: assert property (@(posedge clk) disable iff (reset)
        (dec_valid && !dec_ready) |=> (dec_valid && $stable(dec_data)))
        else $error("decoder output changed while stalled");

endmodule

bind issue_front issue_front_sva u_sva (
    .clk         (clk),
    .reset       (reset),
    .fetch_ready (fetch_ready),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_data  (issue_data),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_data    (dec_data)
);

`default_nettype wire

//--- verification/issue_front_tb.sv
`timescale 1ns/1ns
`default_nettype none

module issue_front_tb;
    import issue_pkg::*;

    localparam int NUM_ATTEMPTS = 2000;
    localparam int DRAIN_LIMIT = 1000;

    logic          clk;
    logic          reset;
    logic          fetch_valid;
    fetch_t        fetch_data;
    logic          issue_ready;
    wire           fetch_ready;
    wire           issue_valid;
    wire decoded_t issue_data;

    integer               seed;
    decoded_t             exp_q[$];
    logic [UUID_BITS-1:0] model_uuid;
    bit                   fetch_taken;
    bit                   fetched_any;
    bit                   drained;
    int                   issued;
    int                   fetched;
    int                   cycle;

    issue_front u_dut (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .fetch_ready (fetch_ready),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .issue_ready (issue_ready)
    );

    always #4 clk = ~clk;

    task automatic fail_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    function automatic bit chance(input int pct);
        logic [31:0] r;
        r = $random(seed);
        return (r % 100) < pct;
    endfunction

    function automatic decoded_t decode_model(input fetch_t f, input logic [UUID_BITS-1:0] id);
        decoded_t d;
        d.uuid = id;
        d.wis = f.wis;
        d.tmask = f.tmask;
        d.ex_type = ex_type_e'(f.instr[31:30]);
        d.op_type = f.instr[29:26];
        d.rd = f.instr[25:21];
        d.rs1 = f.instr[20:16];
        d.rs2 = f.instr[15:11];
        d.rs3 = (d.ex_type == EX_TENSOR) ? d.rd : 5'd0;
        d.wb = (d.rd != 5'd0);
        d.use_imm = (d.ex_type == EX_LSU);
        d.imm = {{(XLEN - 11){f.instr[10]}}, f.instr[10:0]};
        return d;
    endfunction

    // micro-op k of set s reads A from fk and works on the register pair of its set
    function automatic decoded_t tensor_uop(input decoded_t t, input int k);
        decoded_t u;
        int s;
        s = int'(t.op_type[1:0]);
        u = t;
        u.ex_type = EX_FPU;
        u.op_type = OP_FMADD;
        u.wb = 1'b1;
        u.use_imm = 1'b0;
        u.imm = '0;
        u.rs1 = REG_BITS'(k);
        u.rs2 = REG_BITS'(8 + 2 * s + k % 2);
        u.rd = REG_BITS'(16 + 2 * s + k % 2);
        u.rs3 = u.rd;
        return u;
    endfunction

    task automatic push_expected(input fetch_t f);
        decoded_t d;
        int k;
        d = decode_model(f, model_uuid);
        // 8-bit counter, so it wraps at 256 like the hardware one
        model_uuid = model_uuid + 1'b1;
        if (d.ex_type == EX_TENSOR) begin
            for (k = 0; k < UOPS_PER_SET; k++) begin
                exp_q.push_back(tensor_uop(d, k));
            end
        end else begin
            exp_q.push_back(d);
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want, inout bit bad);
        if (got !== want) begin
            $display("ERROR issue_data.%s got 0x%0h expected 0x%0h", name, got, want);
            bad = 1'b1;
        end
    endtask

    task automatic check_issue(input decoded_t got, input decoded_t want);
        bit bad;
        bad = 1'b0;
        compare_field("uuid", 32'(got.uuid), 32'(want.uuid), bad);
        compare_field("wis", 32'(got.wis), 32'(want.wis), bad);
        compare_field("tmask", 32'(got.tmask), 32'(want.tmask), bad);
        compare_field("ex_type", 32'(got.ex_type), 32'(want.ex_type), bad);
        compare_field("op_type", 32'(got.op_type), 32'(want.op_type), bad);
        compare_field("wb", 32'(got.wb), 32'(want.wb), bad);
        compare_field("use_imm", 32'(got.use_imm), 32'(want.use_imm), bad);
        compare_field("imm", got.imm, want.imm, bad);
        compare_field("rd", 32'(got.rd), 32'(want.rd), bad);
        compare_field("rs1", 32'(got.rs1), 32'(want.rs1), bad);
        compare_field("rs2", 32'(got.rs2), 32'(want.rs2), bad);
        compare_field("rs3", 32'(got.rs3), 32'(want.rs3), bad);
        if (bad) begin
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, want);
            fail_run();
        end
    endtask

    task automatic drive_inputs(input bit allow_fetch);
        logic [31:0] r;
        issue_ready = chance(60);
        // a word the decoder has not taken yet stays on the bus unchanged
        if (!fetch_valid || fetch_taken) begin
            fetch_valid = allow_fetch && chance(70);
            r = $random(seed);
            fetch_data.instr = $random(seed);
            fetch_data.wis = r[1:0];
            fetch_data.tmask = r[5:2];
        end
    endtask

    task automatic sample_outputs();
        if (!fetched_any) begin
            check_bit("issue_valid", issue_valid, 1'b0);
        end
        if (issue_valid && issue_ready) begin
            if (exp_q.size() == 0) begin
                $display("issue transfer seen while the model expects nothing");
                fail_run();
            end else begin
                check_issue(issue_data, exp_q.pop_front());
                issued++;
            end
        end
        fetch_taken = fetch_valid && fetch_ready;
        if (fetch_taken) begin
            push_expected(fetch_data);
            fetched++;
            fetched_any = 1'b1;
        end
    endtask

    // inputs change on the falling edge, results are taken on the rising edge
    task automatic step_cycle(input bit allow_fetch);
        @(negedge clk);
        drive_inputs(allow_fetch);
        @(posedge clk);
        sample_outputs();
    endtask

    initial begin
        seed = 47609;
        clk = 1'b0;
        reset = 1'b1;
        fetch_valid = 1'b0;
        fetch_data = '0;
        issue_ready = 1'b0;
        model_uuid = '0;
        fetch_taken = 1'b0;
        fetched_any = 1'b0;
        drained = 1'b0;
        issued = 0;
        fetched = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (cycle = 0; cycle < 6; cycle++) begin
            step_cycle(1'b0);
        end
        for (cycle = 0; cycle < NUM_ATTEMPTS; cycle++) begin
            step_cycle(1'b1);
        end
        for (cycle = 0; cycle < DRAIN_LIMIT && !drained; cycle++) begin
            if (exp_q.size() == 0 && !fetch_valid) begin
                drained = 1'b1;
            end else begin
                step_cycle(1'b0);
            end
        end
        // nothing more may leave once the model is empty
        for (cycle = 0; cycle < 8; cycle++) begin
            step_cycle(1'b0);
        end
        if (!drained) begin
            $display("drain timed out with %0d results still expected", exp_q.size());
            fail_run();
        end else begin
            $display("%0d fetches accepted, %0d results issued", fetched, issued);
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire
